// ==== common/pwm_bus_pkg.sv ====
`default_nettype none

package pwm_bus_pkg;

    // One register write, accepted on the clock edge where valid is high
    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
        logic [31:0] data;
    } reg_write_t;

    // Which block an address belongs to
    typedef enum logic [1:0] {
        SPACE_TIMEBASE,
        SPACE_CHAIN,
        SPACE_NONE
    } reg_space_e;

    // Timebase block at addresses 0x000 to 0x0FF
    // Control bit 0 is run and bit 1 selects the external timebase
    localparam logic [7:0] TB_CONTROL     = 8'h00;
    localparam logic [7:0] TB_PRESCALE    = 8'h04;
    localparam logic [7:0] TB_FAULT_CLEAR = 8'h08;

    // Chain n sits at 0x100 * (n + 1) with the offsets below inside that page
    localparam logic [7:0] CH_CMP_LOW     = 8'h00;
    localparam logic [7:0] CH_CMP_HIGH    = 8'h04;
    localparam logic [7:0] CH_DEADTIME    = 8'h08;
    localparam logic [7:0] CH_PERIOD      = 8'h0C;
    localparam logic [7:0] CH_PHASE       = 8'h10;
    localparam logic [7:0] CH_MODE        = 8'h14;
    localparam logic [7:0] CH_OUT_ENABLE  = 8'h18;

endpackage

`default_nettype wire

// ==== common/pwm_cfg_pkg.sv ====
`default_nettype none

package pwm_cfg_pkg;

    typedef enum logic {
        MODE_UP      = 1'b0,
        MODE_UP_DOWN = 1'b1
    } counter_mode_e;

    // Counter-sized fields are 16 bits here
    // A chain with a narrower counter only looks at the low bits
    typedef struct packed {
        logic [15:0]   cmp_low;
        logic [15:0]   cmp_high;
        logic [15:0]   period;
        logic [15:0]   phase;
        logic [7:0]    deadtime;
        counter_mode_e mode;
        logic          out_enable;
    } chain_cfg_t;

    typedef struct packed {
        logic        run;
        logic        ext_select;
        logic [15:0] prescale;
    } timebase_cfg_t;

endpackage

`default_nettype wire

// ==== logic/pwm_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_regs #(
    parameter int N_CHAINS = 6
) (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  pwm_bus_pkg::reg_write_t                  reg_wr,
    output pwm_cfg_pkg::timebase_cfg_t               timebase_cfg,
    output pwm_cfg_pkg::chain_cfg_t [N_CHAINS-1:0]   chain_cfg,
    output logic                                     fault_clear
);
    import pwm_bus_pkg::*;
    import pwm_cfg_pkg::*;

    reg_space_e space;
    logic [7:0] page;
    logic [7:0] chain_sel;
    logic [7:0] offset;

    assign page      = reg_wr.addr[15:8];
    assign offset    = reg_wr.addr[7:0];
    // Page 0 is the timebase and chains start at page 1
    assign chain_sel = page - 8'd1;

    always_comb begin
        if (page == 8'd0) begin
            space = SPACE_TIMEBASE;
        end else if (chain_sel < 8'(N_CHAINS)) begin
            space = SPACE_CHAIN;
        end else begin
            space = SPACE_NONE;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            timebase_cfg <= '0;
            chain_cfg    <= '0;
            fault_clear  <= 1'b0;
        end else begin
            fault_clear <= 1'b0;

            if (reg_wr.valid && space == SPACE_TIMEBASE) begin
                case (offset)
                    TB_CONTROL: begin
                        timebase_cfg.run        <= reg_wr.data[0];
                        timebase_cfg.ext_select <= reg_wr.data[1];
                    end
                    TB_PRESCALE:    timebase_cfg.prescale <= reg_wr.data[15:0];
                    // Any write here clears the fault whatever the data
                    TB_FAULT_CLEAR: fault_clear <= 1'b1;
                    default: ;
                endcase
            end

            if (reg_wr.valid && space == SPACE_CHAIN) begin
                for (int n = 0; n < N_CHAINS; n++) begin
                    if (chain_sel == 8'(n)) begin
                        case (offset)
                            CH_CMP_LOW:    chain_cfg[n].cmp_low  <= reg_wr.data[15:0];
                            CH_CMP_HIGH:   chain_cfg[n].cmp_high <= reg_wr.data[15:0];
                            CH_DEADTIME:   chain_cfg[n].deadtime <= reg_wr.data[7:0];
                            CH_PERIOD:     chain_cfg[n].period   <= reg_wr.data[15:0];
                            CH_PHASE:      chain_cfg[n].phase    <= reg_wr.data[15:0];
                            CH_MODE: begin
                                chain_cfg[n].mode <= counter_mode_e'(reg_wr.data[0]);
                            end
                            CH_OUT_ENABLE: chain_cfg[n].out_enable <= reg_wr.data[0];
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

    // A clear pulse lasting two cycles needs a write behind each cycle
    fault_clear_single: assert property (
        @(posedge clock) disable iff (!rst_n)
        fault_clear && $past(fault_clear) |-> $past(reg_wr.valid) && $past(reg_wr.valid, 2)
    ) else $error("fault_clear held without back-to-back writes");

endmodule

`default_nettype wire

// ==== logic/pwm_timebase.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_timebase (
    input  logic                       clock,
    input  logic                       rst_n,
    input  pwm_cfg_pkg::timebase_cfg_t cfg,
    input  logic                       ext_timebase,
    output logic                       tick,
    output logic                       running
);

    logic [15:0] presc_cnt;
    logic        presc_hit;
    // Two synchronizer stages plus one more for edge detection
    logic [2:0]  ext_sync;
    logic        ext_edge;
    logic        run_rise;

    assign run_rise  = cfg.run & ~running;
    // >= so a prescale lowered on the fly does not run the counter around
    assign presc_hit = presc_cnt >= cfg.prescale;
    assign ext_edge  = ext_sync[1] & ~ext_sync[2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            running   <= 1'b0;
            presc_cnt <= '0;
            ext_sync  <= '0;
            tick      <= 1'b0;
        end else begin
            running  <= cfg.run;
            ext_sync <= {ext_sync[1:0], ext_timebase};

            if (run_rise) begin
                presc_cnt <= '0;
            end else if (running) begin
                presc_cnt <= presc_hit ? '0 : presc_cnt + 16'd1;
            end

            // Gated by cfg.run too, so no tick lands on the cycle running drops
            tick <= cfg.run & running & (cfg.ext_select ? ext_edge : presc_hit);
        end
    end

    tick_needs_running: assert property (
        @(posedge clock) disable iff (!rst_n)
        tick |-> running
    ) else $error("tick while timebase stopped");

endmodule

`default_nettype wire

// ==== chain/pwm_chain.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_chain #(
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    tick,
    input  logic                    running,
    input  pwm_cfg_pkg::chain_cfg_t shadow_cfg,
    input  logic                    fault_active,
    output logic                    pwm_high,
    output logic                    pwm_low
);
    import pwm_cfg_pkg::*;

    localparam int CW = COUNTER_WIDTH;

    chain_cfg_t    active;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic          count_up;
    logic          count_up_next;
    logic          running_d;
    logic          start;

    logic [CW-1:0] period;
    logic [CW-1:0] cmp_low;
    logic [CW-1:0] cmp_high;

    logic          raw_high;
    logic          blank;
    // Index 0 is the high side and index 1 the low side
    logic [1:0]    raw;
    logic [1:0]    side_q;
    logic [7:0]    dt_cnt [2];

    assign period   = active.period[CW-1:0];
    assign cmp_low  = active.cmp_low[CW-1:0];
    assign cmp_high = active.cmp_high[CW-1:0];

    assign start = running & ~running_d;

    // Next counter value for the coming tick
    always_comb begin
        count_next    = count;
        count_up_next = count_up;
        if (active.mode == MODE_UP) begin
            count_next    = (count >= period) ? '0 : count + 1'b1;
            count_up_next = 1'b1;
        end else if (count_up) begin
            if (count < period) begin
                count_next = count + 1'b1;
            end else if (count != '0) begin
                // Reached the top, turn around
                count_next    = count - 1'b1;
                count_up_next = 1'b0;
            end
        end else if (count == '0) begin
            count_up_next = 1'b1;
            if (period != '0) begin
                count_next = CW'(1);
            end
        end else begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            active    <= '0;
            count     <= '0;
            count_up  <= 1'b1;
            running_d <= 1'b0;
        end else begin
            running_d <= running;
            if (start) begin
                active   <= shadow_cfg;
                count    <= shadow_cfg.phase[CW-1:0];
                count_up <= 1'b1;
            end else if (tick && running) begin
                count    <= count_next;
                count_up <= count_up_next;
                // New settings only take over at the bottom of the cycle
                if (count_next == '0) begin
                    active <= shadow_cfg;
                end
            end
        end
    end

    assign raw_high = (count >= cmp_low) && (count < cmp_high);
    assign raw      = {~raw_high, raw_high};
    assign blank    = !running || !active.out_enable || fault_active;

    // A rising side waits deadtime clocks and a falling side drops at once
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            side_q <= '0;
            for (int s = 0; s < 2; s++) begin
                dt_cnt[s] <= '0;
            end
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (blank || !raw[s]) begin
                    dt_cnt[s] <= '0;
                    side_q[s] <= 1'b0;
                end else if (dt_cnt[s] >= active.deadtime) begin
                    side_q[s] <= 1'b1;
                end else begin
                    dt_cnt[s] <= dt_cnt[s] + 8'd1;
                end
            end
        end
    end

    assign pwm_high = side_q[0];
    assign pwm_low  = side_q[1];

    no_shoot_through: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(pwm_high && pwm_low)
    ) else $error("high and low side both on");

endmodule

`default_nettype wire

// ==== logic/pwm_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_generator #(
    parameter int N_CHAINS      = 6,
    parameter int COUNTER_WIDTH = 16
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  pwm_bus_pkg::reg_write_t reg_wr,
    input  logic                    ext_timebase,
    input  logic                    fault,
    output logic [2*N_CHAINS-1:0]   pwm_out
);
    import pwm_cfg_pkg::*;

    timebase_cfg_t                timebase_cfg;
    chain_cfg_t [N_CHAINS-1:0]    chain_cfg;
    logic                         fault_clear;
    logic                         fault_active;
    logic                         tick;
    logic                         running;

    pwm_regs #(
        .N_CHAINS (N_CHAINS)
    ) regs_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .timebase_cfg (timebase_cfg),
        .chain_cfg    (chain_cfg),
        .fault_clear  (fault_clear)
    );

    pwm_timebase timebase_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .cfg          (timebase_cfg),
        .ext_timebase (ext_timebase),
        .tick         (tick),
        .running      (running)
    );

    // Fault wins over a clear that arrives while it is still asserted
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fault_active <= 1'b0;
        end else if (fault) begin
            fault_active <= 1'b1;
        end else if (fault_clear) begin
            fault_active <= 1'b0;
        end
    end

    for (genvar n = 0; n < N_CHAINS; n++) begin : g_chain
        pwm_chain #(
            .COUNTER_WIDTH (COUNTER_WIDTH)
        ) chain_i (
            .clock        (clock),
            .rst_n        (rst_n),
            .tick         (tick),
            .running      (running),
            .shadow_cfg   (chain_cfg[n]),
            .fault_active (fault_active),
            .pwm_high     (pwm_out[2*n]),
            .pwm_low      (pwm_out[2*n+1])
        );
    end

endmodule

`default_nettype wire

// ==== tests/pwm_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_checker #(
    parameter int N_CHAINS = 6
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  pwm_bus_pkg::reg_write_t reg_wr,
    input  logic                    ext_timebase,
    input  logic                    fault,
    input  logic [2*N_CHAINS-1:0]   pwm_out,
    input  logic [2:0]              test_id,
    input  logic                    test_end,
    input  logic                    all_done,
    output int                      fail_tests
);
    import pwm_cfg_pkg::*;

    // Page 0 holds the timebase registers and page n+1 those of chain n
    localparam logic [7:0] R_CONTROL  = 8'h00;
    localparam logic [7:0] R_PRESCALE = 8'h04;
    localparam logic [7:0] R_CLEAR    = 8'h08;
    localparam logic [7:0] R_LOW      = 8'h00;
    localparam logic [7:0] R_HIGH     = 8'h04;
    localparam logic [7:0] R_DEAD     = 8'h08;
    localparam logic [7:0] R_PERIOD   = 8'h0C;
    localparam logic [7:0] R_PHASE    = 8'h10;
    localparam logic [7:0] R_MODE     = 8'h14;
    localparam logic [7:0] R_ENABLE   = 8'h18;

    typedef struct packed {
        logic        run;
        logic        ext_sel;
        logic [15:0] prescale;
        logic        clr;
        logic        flt;
        logic        running;
        logic        running_d;
        logic        tick;
        logic [15:0] presc;
        logic [2:0]  sync;
    } timebase_model_t;

    typedef struct packed {
        chain_cfg_t      shadow;
        chain_cfg_t      act;
        logic [15:0]     cnt;
        logic            up;
        logic [1:0][7:0] dt;
        logic [1:0]      side;
    } chain_model_t;

    timebase_model_t t;
    chain_model_t    ch [N_CHAINS];
    logic [7:0]      page;
    logic [7:0]      off;
    int              test_errs = 0;
    int              pass_tests = 0;
    string           names [6] = '{"reset state", "up mode", "up-down dead time",
                                   "shadow update", "external timebase", "fault and enable"};

    assign page = reg_wr.addr[15:8];
    assign off  = reg_wr.addr[7:0];

    initial fail_tests = 0;

    // Counter step on a tick with the direction returned on top of the count
    function automatic logic [16:0] step(input chain_cfg_t c, input logic [15:0] v,
                                         input logic dir_up);
        if (c.mode == MODE_UP) return {1'b1, (v >= c.period) ? 16'd0 : v + 16'd1};
        if (dir_up && v < c.period) return {1'b1, v + 16'd1};
        if (dir_up && v != 16'd0) return {1'b0, v - 16'd1};
        if (dir_up) return {1'b1, v};
        if (v == 16'd0) return {1'b1, (c.period != 16'd0) ? 16'd1 : 16'd0};
        return {1'b0, v - 16'd1};
    endfunction

    always @(posedge clock or negedge rst_n) begin
        logic [16:0] nxt;
        logic        raw_hi;
        logic        blank;
        logic        want;
        if (!rst_n) begin
            t <= '0;
            for (int n = 0; n < N_CHAINS; n++) begin
                ch[n] <= '0;
            end
        end else begin
            t.clr <= reg_wr.valid && page == 8'd0 && off == R_CLEAR;
            if (reg_wr.valid && page == 8'd0 && off == R_CONTROL) begin
                t.run     <= reg_wr.data[0];
                t.ext_sel <= reg_wr.data[1];
            end
            if (reg_wr.valid && page == 8'd0 && off == R_PRESCALE) begin
                t.prescale <= reg_wr.data[15:0];
            end
            t.running   <= t.run;
            t.running_d <= t.running;
            t.sync      <= {t.sync[1:0], ext_timebase};
            if (t.run && !t.running) begin
                t.presc <= 16'd0;
            end else if (t.running) begin
                t.presc <= (t.presc >= t.prescale) ? 16'd0 : t.presc + 16'd1;
            end
            // Synchronized rising edge or prescaler wrap while running
            t.tick <= t.run && t.running &&
                      (t.ext_sel ? (t.sync[1] && !t.sync[2]) : (t.presc >= t.prescale));
            if (fault) begin
                t.flt <= 1'b1;
            end else if (t.clr) begin
                t.flt <= 1'b0;
            end

            for (int n = 0; n < N_CHAINS; n++) begin
                if (reg_wr.valid && page == 8'(n + 1)) begin
                    case (off)
                        R_LOW:    ch[n].shadow.cmp_low    <= reg_wr.data[15:0];
                        R_HIGH:   ch[n].shadow.cmp_high   <= reg_wr.data[15:0];
                        R_DEAD:   ch[n].shadow.deadtime   <= reg_wr.data[7:0];
                        R_PERIOD: ch[n].shadow.period     <= reg_wr.data[15:0];
                        R_PHASE:  ch[n].shadow.phase      <= reg_wr.data[15:0];
                        R_MODE:   ch[n].shadow.mode       <= counter_mode_e'(reg_wr.data[0]);
                        R_ENABLE: ch[n].shadow.out_enable <= reg_wr.data[0];
                        default: ;
                    endcase
                end

                nxt = step(ch[n].act, ch[n].cnt, ch[n].up);
                if (t.running && !t.running_d) begin
                    ch[n].act <= ch[n].shadow;
                    ch[n].cnt <= ch[n].shadow.phase;
                    ch[n].up  <= 1'b1;
                end else if (t.tick && t.running) begin
                    ch[n].cnt <= nxt[15:0];
                    ch[n].up  <= nxt[16];
                    // Shadow takes over at the bottom of the count
                    if (nxt[15:0] == 16'd0) begin
                        ch[n].act <= ch[n].shadow;
                    end
                end

                raw_hi = ch[n].cnt >= ch[n].act.cmp_low && ch[n].cnt < ch[n].act.cmp_high;
                blank  = !t.running || !ch[n].act.out_enable || t.flt;
                for (int s = 0; s < 2; s++) begin
                    want = (s == 0) ? raw_hi : !raw_hi;
                    if (blank || !want) begin
                        ch[n].dt[s]   <= 8'd0;
                        ch[n].side[s] <= 1'b0;
                    end else if (ch[n].dt[s] >= ch[n].act.deadtime) begin
                        ch[n].side[s] <= 1'b1;
                    end else begin
                        ch[n].dt[s] <= ch[n].dt[s] + 8'd1;
                    end
                end
            end
        end
    end

    // Outputs still hold the values of the previous edge here
    always @(posedge clock) begin
        if (rst_n) begin
            for (int n = 0; n < N_CHAINS; n++) begin
                for (int s = 0; s < 2; s++) begin
                    if (pwm_out[2*n+s] !== ch[n].side[s]) begin
                        $display("ERR %0t pwm_out[%0d] expected %0b actual %0b",
                                 $time, 2*n+s, ch[n].side[s], pwm_out[2*n+s]);
                        test_errs++;
                    end
                end
                if (pwm_out[2*n] === 1'b1 && pwm_out[2*n+1] === 1'b1) begin
                    $display("Chain %0d drove its high and low side together at %0t", n, $time);
                    test_errs++;
                end
            end
        end
        if (test_end) begin
            $display("Test %0d %s: %s with %0d mismatches", test_id + 1, names[test_id],
                     (test_errs == 0) ? "pass" : "fail", test_errs);
            if (test_errs == 0) begin
                pass_tests++;
            end else begin
                fail_tests++;
            end
            test_errs = 0;
        end
        if (all_done) begin
            $display("Tests passing %0d, tests failing %0d", pass_tests, fail_tests);
        end
    end

endmodule

`default_nettype wire

// ==== tests/pwm_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_tb;
    import pwm_bus_pkg::*;

    localparam int N_CHAINS   = 6;
    localparam int CLK_PERIOD = 20;
    // Upper bound on the summed test lengths in clocks
    localparam int RUN_CYCLES = 14600;

    logic                  clock;
    logic                  rst_n;
    reg_write_t            reg_wr;
    logic                  ext_timebase;
    logic                  fault;
    logic [2*N_CHAINS-1:0] pwm_out;
    logic [2:0]            test_id;
    logic                  test_end;
    logic                  all_done;
    int                    fail_tests;
    logic [15:0]           lfsr;
    logic [15:0]           periods [N_CHAINS];

    pwm_generator #(
        .N_CHAINS      (N_CHAINS),
        .COUNTER_WIDTH (16)
    ) dut_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .ext_timebase (ext_timebase),
        .fault        (fault),
        .pwm_out      (pwm_out)
    );

    pwm_checker #(
        .N_CHAINS (N_CHAINS)
    ) checker_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .ext_timebase (ext_timebase),
        .fault        (fault),
        .pwm_out      (pwm_out),
        .test_id      (test_id),
        .test_end     (test_end),
        .all_done     (all_done),
        .fail_tests   (fail_tests)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int width);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < width; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        @(negedge clock);
        reg_wr = '{valid: 1'b1, addr: addr, data: data};
        @(negedge clock);
        reg_wr = '0;
    endtask

    task automatic write_chain(input int n, input logic [7:0] offset, input logic [15:0] value);
        write_reg({8'(n + 1), offset}, {16'd0, value});
    endtask

    task automatic new_thresholds(input int n);
        logic [15:0] low;
        low = rand_bits(16) % (periods[n] + 16'd1);
        write_chain(n, CH_CMP_LOW, low);
        write_chain(n, CH_CMP_HIGH, low + rand_bits(16) % (periods[n] + 16'd2 - low));
    endtask

    // some_off leaves a random set of chains disabled
    task automatic config_all(input logic up_down, input logic use_dt, input logic some_off);
        for (int n = 0; n < N_CHAINS; n++) begin
            periods[n] = 16'd8 + rand_bits(6);
            write_chain(n, CH_PERIOD, periods[n]);
            new_thresholds(n);
            write_chain(n, CH_DEADTIME, use_dt ? rand_bits(3) + 16'd1 : 16'd0);
            write_chain(n, CH_PHASE, rand_bits(16) % (periods[n] + 16'd1));
            write_chain(n, CH_MODE, {15'd0, up_down});
            write_chain(n, CH_OUT_ENABLE, some_off ? rand_bits(1) : 16'd1);
        end
    endtask

    task automatic start_run(input logic ext);
        write_reg({8'h00, TB_PRESCALE}, {16'd0, rand_bits(2)});
        write_reg({8'h00, TB_CONTROL}, {30'd0, ext, 1'b1});
    endtask

    task automatic stop_run();
        write_reg({8'h00, TB_CONTROL}, 32'd0);
        wait_cycles(5);
    endtask

    task automatic end_test(input logic [2:0] id);
        @(negedge clock);
        test_id  = id;
        test_end = 1'b1;
        @(negedge clock);
        test_end = 1'b0;
    endtask

    initial begin
        lfsr         = 16'(83822);
        rst_n        = 1'b0;
        reg_wr       = '0;
        ext_timebase = 1'b0;
        fault        = 1'b0;
        test_id      = 3'd0;
        test_end     = 1'b0;
        all_done     = 1'b0;
        wait_cycles(10);
        rst_n = 1'b1;

        // Configured but never started
        config_all(1'b0, 1'b0, 1'b0);
        wait_cycles(100);
        end_test(3'd0);

        start_run(1'b0);
        wait_cycles(2500);
        stop_run();
        end_test(3'd1);

        config_all(1'b1, 1'b1, 1'b0);
        start_run(1'b0);
        wait_cycles(3000);
        stop_run();
        end_test(3'd2);

        // Thresholds change while the counters are mid-period
        config_all(1'b0, 1'b0, 1'b0);
        start_run(1'b0);
        wait_cycles(150);
        for (int n = 0; n < N_CHAINS; n++) begin
            new_thresholds(n);
        end
        wait_cycles(2000);
        stop_run();
        end_test(3'd3);

        config_all(1'b1, 1'b0, 1'b0);
        start_run(1'b1);
        repeat (400) begin
            wait_cycles(4 + rand_bits(3));
            ext_timebase = ~ext_timebase;
        end
        stop_run();
        end_test(3'd4);

        config_all(1'b0, 1'b1, 1'b1);
        start_run(1'b0);
        repeat (4) begin
            wait_cycles(100 + rand_bits(8));
            fault = 1'b1;
            wait_cycles(1 + rand_bits(2));
            fault = 1'b0;
            wait_cycles(50);
            write_reg({8'h00, TB_FAULT_CLEAR}, 32'd0);
        end
        wait_cycles(200);
        stop_run();
        end_test(3'd5);

        @(negedge clock);
        all_done = 1'b1;
        @(negedge clock);
        all_done = 1'b0;
        if (fail_tests == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 12 / 10);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
common/pwm_bus_pkg.sv
common/pwm_cfg_pkg.sv
logic/pwm_regs.sv
logic/pwm_timebase.sv
chain/pwm_chain.sv
logic/pwm_generator.sv
tests/pwm_checker.sv
tests/pwm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PWM generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module pwm_tb -f list.f -o pwm_sim; then
    echo "Build failed"
    exit 1
fi

if ! output=$(./obj_dir/pwm_sim); then
    echo "$output"
    echo "Simulation exited with an error"
    exit 1
fi

echo "$output"

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
